// File: dcache_top.f
+incdir+common
common/dcache_pkg.sv
common/wb_pkg.sv
common/cache_port_if.sv
dcache/dcache_way.sv
dcache/dcache_victim_sel.sv
dcache/dcache_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/wb_mem_model.sv
verification/dcache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dcache_tb
FILELIST = dcache_top.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), fail if the log reports failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: verification/dcache_tb.sv
// data cache testbench with reference model, response compare process and timeout

`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_tb;

  localparam int DIRECTED_OPS   = 15;
  localparam int RANDOM_OPS     = 200;
  localparam int POOL_SIZE      = 40;
  // every pool address plus the six directed writes
  localparam int READBACK_OPS   = POOL_SIZE + 6;
  localparam int NUM_OPS        = DIRECTED_OPS + RANDOM_OPS + READBACK_OPS;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 100;

  logic            clock;
  logic            reset;
  logic            cpu_cyc;
  logic            cpu_stb;
  logic            cpu_we;
  wb_pkg::wb_adr_t cpu_adr;
  wb_pkg::wb_dat_t cpu_dat_w;
  wb_pkg::wb_dat_t cpu_dat_r;
  logic            cpu_ack;
  logic            mem_cyc;
  logic            mem_stb;
  logic            mem_we;
  wb_pkg::wb_adr_t mem_adr;
  wb_pkg::wb_dat_t mem_dat_w;
  wb_pkg::wb_dat_t mem_dat_r;
  logic            mem_ack;
  int              mem_reads;
  int              mem_writes;
  wb_pkg::wb_adr_t last_wr_adr;
  wb_pkg::wb_dat_t last_wr_dat;

  int          cycle_count = 0;
  int          check_count = 0;
  int          mismatch_count = 0;
  int          other_count = 0;
  logic [31:0] lfsr_state;

  // last written value per address
  wb_pkg::wb_dat_t shadow [wb_pkg::wb_adr_t];
  // resident tags per set, oldest fill first
  logic [11:0]     resident_tag [`DCACHE_NUM_IDX][$];
  bit              resident_dirty [`DCACHE_NUM_IDX][$];
  string           pend_name [$];
  bit              pend_read [$];
  wb_pkg::wb_dat_t pend_data [$];
  wb_pkg::wb_adr_t pool [POOL_SIZE];

  dcache_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_we    (cpu_we),
    .cpu_adr   (cpu_adr),
    .cpu_dat_w (cpu_dat_w),
    .cpu_dat_r (cpu_dat_r),
    .cpu_ack   (cpu_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack)
  );

  wb_mem_model mem_i (
    .clock       (clock),
    .reset       (reset),
    .cyc         (mem_cyc),
    .stb         (mem_stb),
    .we          (mem_we),
    .adr         (mem_adr),
    .dat_w       (mem_dat_w),
    .dat_r       (mem_dat_r),
    .ack         (mem_ack),
    .read_count  (mem_reads),
    .write_count (mem_writes),
    .last_wr_adr (last_wr_adr),
    .last_wr_dat (last_wr_dat)
  );

  function automatic wb_pkg::wb_dat_t initial_pattern(wb_pkg::wb_adr_t adr);
    return {32'h0, ~adr, adr};
  endfunction

  // expected read value
  function automatic wb_pkg::wb_dat_t expected_read(wb_pkg::wb_adr_t adr);
    if (shadow.exists(adr)) begin
      return shadow[adr];
    end
    return initial_pattern(adr);
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] random_bits(int count);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // one processor access with predicted hit, victim and memory traffic
  task automatic access(input string name, input bit we, input wb_pkg::wb_adr_t adr,
                        input wb_pkg::wb_dat_t wdat);
    logic [11:0]     tag;
    logic [3:0]      set_idx;
    int              reads_before;
    int              writes_before;
    bit              hit;
    bit              writeback;
    wb_pkg::wb_adr_t wb_adr;
    tag       = adr[15:4];
    set_idx   = adr[3:0];
    hit       = 1'b0;
    writeback = 1'b0;
    wb_adr    = '0;
    for (int i = 0; i < resident_tag[set_idx].size(); i++) begin
      if (resident_tag[set_idx][i] == tag) begin
        hit = 1'b1;
        if (we) begin
          resident_dirty[set_idx][i] = 1'b1;
        end
      end
    end
    if (!hit) begin
      // oldest fill leaves once all ways are in use
      if (resident_tag[set_idx].size() == `DCACHE_NUM_WAY) begin
        wb_adr    = {resident_tag[set_idx].pop_front(), set_idx};
        writeback = resident_dirty[set_idx].pop_front();
      end
      resident_tag[set_idx].push_back(tag);
      resident_dirty[set_idx].push_back(we);
    end
    pend_name.push_back(name);
    pend_read.push_back(!we);
    pend_data.push_back(expected_read(adr));
    reads_before  = mem_reads;
    writes_before = mem_writes;
    @(negedge clock);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = wdat;
    do begin
      @(negedge clock);
    end while (!cpu_ack);
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
    check_value({name, " memory reads"}, 64'(!hit && !we), 64'(mem_reads - reads_before));
    check_value({name, " memory writes"}, 64'(writeback), 64'(mem_writes - writes_before));
    if (writeback) begin
      check_value({name, " writeback address"}, 64'(wb_adr), 64'(last_wr_adr));
      check_value({name, " writeback data"}, expected_read(wb_adr), last_wr_dat);
    end
    if (we) begin
      shadow[adr] = wdat;
    end
  endtask

  // read responses against the queued expectations
  always @(negedge clock) begin : compare_response
    string           resp_name;
    bit              resp_read;
    wb_pkg::wb_dat_t resp_data;
    if (!reset && cpu_ack) begin
      if (pend_name.size() == 0) begin
        other_count++;
        $display("cpu_ack arrived with no request outstanding");
      end else begin
        resp_name = pend_name.pop_front();
        resp_read = pend_read.pop_front();
        resp_data = pend_data.pop_front();
        if (resp_read) begin
          check_value(resp_name, resp_data, cpu_dat_r);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin : stimulus
    wb_pkg::wb_adr_t keys [$];
    logic [63:0]     rnd;
    bit              we_bit;
    int              idx;
    reset      = 1'b1;
    cpu_cyc    = 1'b0;
    cpu_stb    = 1'b0;
    cpu_we     = 1'b0;
    cpu_adr    = '0;
    cpu_dat_w  = '0;
    lfsr_state = 32'd92230;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    access("untouched read", 1'b0, 16'h0123, '0);
    access("write then read", 1'b1, 16'h0456, 64'h0bad_cafe_1234_5678);
    access("write then read", 1'b0, 16'h0456, '0);
    access("repeat read", 1'b0, 16'h0123, '0);
    // five dirty tags in set 5, then the evicted one again
    for (int t = 1; t <= 5; t++) begin
      access("dirty eviction", 1'b1, {12'(t), 4'h5}, random_bits(64));
    end
    access("dirty eviction", 1'b0, {12'h001, 4'h5}, '0);
    for (int t = 1; t <= 5; t++) begin
      access("clean eviction", 1'b0, {12'(t), 4'h9}, '0);
    end

    // pool spread over sets 8 to 11 so evictions are frequent
    for (int i = 0; i < POOL_SIZE; i++) begin
      rnd     = random_bits(12);
      pool[i] = {rnd[11:0], 2'b10, 2'(i)};
    end
    for (int i = 0; i < RANDOM_OPS; i++) begin
      rnd    = random_bits(1);
      we_bit = rnd[0];
      rnd    = random_bits(6);
      idx    = int'(rnd[5:0]) % POOL_SIZE;
      access("random mix", we_bit, pool[idx], random_bits(64));
    end

    foreach (shadow[a]) begin
      keys.push_back(a);
    end
    foreach (keys[k]) begin
      access("dirty readback", 1'b0, keys[k], '0);
    end

    @(negedge clock);
    $display("done: %0d checks, %0d mismatches, %0d other errors",
             check_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verification/wb_mem_model.sv
// Wishbone classic slave memory with two wait states, patterned contents and access counters

`timescale 1ns/100ps

`include "dcache_config.svh"

module wb_mem_model (
  input  logic            clock,
  input  logic            reset,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  wb_pkg::wb_adr_t adr,
  input  wb_pkg::wb_dat_t dat_w,
  output wb_pkg::wb_dat_t dat_r,
  output logic            ack,
  output int              read_count,
  output int              write_count,
  output wb_pkg::wb_adr_t last_wr_adr,
  output wb_pkg::wb_dat_t last_wr_dat
);

  localparam int DEPTH       = 1 << `DCACHE_ADDR_W;
  localparam int WAIT_STATES = 2;

  wb_pkg::wb_dat_t mem [DEPTH];
  int              wait_count;

  // address in the low half word, its inverse above it
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {32'h0, ~16'(a), 16'(a)};
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      ack         <= 1'b0;
      wait_count  <= 0;
      read_count  <= 0;
      write_count <= 0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        // request taken from the bus on the acknowledging cycle
        if (wait_count == WAIT_STATES) begin
          ack        <= 1'b1;
          wait_count <= 0;
          if (we) begin
            mem[adr]    <= dat_w;
            last_wr_adr <= adr;
            last_wr_dat <= dat_w;
            write_count <= write_count + 1;
          end else begin
            dat_r      <= mem[adr];
            read_count <= read_count + 1;
          end
        end else begin
          wait_count <= wait_count + 1;
        end
      end
    end
  end

endmodule

// File: hdl/dcache_top.sv
// data cache top level with Wishbone processor and memory ports

`timescale 1ns/100ps

module dcache_top (
  input  logic            clock,
  input  logic            reset,
  input  logic            cpu_cyc,
  input  logic            cpu_stb,
  input  logic            cpu_we,
  input  wb_pkg::wb_adr_t cpu_adr,
  input  wb_pkg::wb_dat_t cpu_dat_w,
  output wb_pkg::wb_dat_t cpu_dat_r,
  output logic            cpu_ack,
  output logic            mem_cyc,
  output logic            mem_stb,
  output logic            mem_we,
  output wb_pkg::wb_adr_t mem_adr,
  output wb_pkg::wb_dat_t mem_dat_w,
  input  wb_pkg::wb_dat_t mem_dat_r,
  input  logic            mem_ack
);

  cache_port_if port_if ();

  dcache_ctrl ctrl_i (
    .clock     (clock),
    .reset     (reset),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_we    (cpu_we),
    .cpu_adr   (cpu_adr),
    .cpu_dat_w (cpu_dat_w),
    .cpu_dat_r (cpu_dat_r),
    .cpu_ack   (cpu_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack),
    .port      (port_if.ctrl)
  );

  dcache_array array_i (
    .clock (clock),
    .reset (reset),
    .port  (port_if.array)
  );

endmodule

// File: hdl/dcache_ctrl.sv
// cache controller FSM for hits, misses, writebacks and fills over Wishbone

`timescale 1ns/100ps

module dcache_ctrl (
  input  logic            clock,
  input  logic            reset,
  input  logic            cpu_cyc,
  input  logic            cpu_stb,
  input  logic            cpu_we,
  input  wb_pkg::wb_adr_t cpu_adr,
  input  wb_pkg::wb_dat_t cpu_dat_w,
  output wb_pkg::wb_dat_t cpu_dat_r,
  output logic            cpu_ack,
  output logic            mem_cyc,
  output logic            mem_stb,
  output logic            mem_we,
  output wb_pkg::wb_adr_t mem_adr,
  output wb_pkg::wb_dat_t mem_dat_w,
  input  wb_pkg::wb_dat_t mem_dat_r,
  input  logic            mem_ack,
  cache_port_if.ctrl      port
);

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, FETCH, RESPOND} state_t;

  state_t            state;
  logic              req_we;
  dcache_pkg::addr_t req_adr;
  wb_pkg::wb_dat_t   req_dat;
  logic              victim_dirty;

  assign victim_dirty = port.victim.valid && port.victim.dirty;

  // array side follows the state combinationally
  always_comb begin
    port.addr     = req_adr;
    port.wr_en    = 1'b0;
    port.wr_fill  = 1'b0;
    port.wr_data  = req_dat;
    port.wr_dirty = 1'b1;
    case (state)
      LOOKUP: begin
        // write hit, or write miss onto a clean victim
        port.wr_en   = req_we && (port.hit || !victim_dirty);
        port.wr_fill = !port.hit;
      end
      WRITEBACK: begin
        port.wr_en   = mem_ack && req_we;
        port.wr_fill = 1'b1;
      end
      FETCH: begin
        port.wr_en    = mem_cyc && mem_ack;
        port.wr_fill  = 1'b1;
        port.wr_data  = mem_dat_r;
        port.wr_dirty = 1'b0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= IDLE;
      cpu_ack <= 1'b0;
      mem_cyc <= 1'b0;
      mem_stb <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      cpu_ack <= 1'b0;
      case (state)
        IDLE: begin
          if (cpu_cyc && cpu_stb) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (port.hit || (req_we && !victim_dirty)) begin
            cpu_ack <= 1'b1;
            state   <= RESPOND;
          end else if (victim_dirty) begin
            mem_cyc <= 1'b1;
            mem_stb <= 1'b1;
            mem_we  <= 1'b1;
            state   <= WRITEBACK;
          end else begin
            state <= FETCH;
          end
        end
        WRITEBACK: begin
          if (mem_ack) begin
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            mem_we  <= 1'b0;
            cpu_ack <= req_we;
            state   <= req_we ? RESPOND : FETCH;
          end
        end
        FETCH: begin
          // bus is idle for a cycle before the read starts
          if (!mem_cyc) begin
            mem_cyc <= 1'b1;
            mem_stb <= 1'b1;
          end else if (mem_ack) begin
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            cpu_ack <= 1'b1;
            state   <= RESPOND;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // request, response and bus payload
  always_ff @(posedge clock) begin
    case (state)
      IDLE: begin
        req_we  <= cpu_we;
        req_adr <= cpu_adr;
        req_dat <= cpu_dat_w;
      end
      LOOKUP: begin
        cpu_dat_r <= port.hit_data;
        mem_adr   <= victim_dirty ? {port.victim.tag, req_adr.set_index} : req_adr;
        mem_dat_w <= port.victim.data;
      end
      WRITEBACK: begin
        // fetch address goes out once the writeback is acknowledged
        if (mem_ack) begin
          mem_adr <= req_adr;
        end
      end
      FETCH: begin
        cpu_dat_r <= mem_dat_r;
      end
      default: begin
      end
    endcase
  end

  a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset) mem_stb |-> mem_cyc);

endmodule

// File: dcache/dcache_array.sv
// four-way tag/data array with hit merge, write-way select and victim mux

`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_array (
  input logic         clock,
  input logic         reset,
  cache_port_if.array port
);

  dcache_pkg::way_sel_t way_hit;
  dcache_pkg::way_sel_t victim_way;
  dcache_pkg::way_sel_t wr_sel;
  dcache_pkg::line_t    way_line [`DCACHE_NUM_WAY];
  logic [1:0]           victim_num;
  wb_pkg::wb_dat_t      hit_data;
  logic                 fill;

  assign fill = port.wr_en & port.wr_fill;

  dcache_victim_sel victim_sel_i (
    .clock      (clock),
    .reset      (reset),
    .set_index  (port.addr.set_index),
    .advance    (fill),
    .victim_way (victim_way),
    .victim_num (victim_num)
  );

  // fills go to the victim, plain writes to the hit way
  always_comb begin
    wr_sel = '0;
    if (port.wr_en) begin
      wr_sel = port.wr_fill ? victim_way : way_hit;
    end
  end

  for (genvar w = 0; w < `DCACHE_NUM_WAY; w++) begin : g_way
    dcache_way way_i (
      .clock    (clock),
      .reset    (reset),
      .addr     (port.addr),
      .wr_en    (wr_sel[w]),
      .wr_data  (port.wr_data),
      .wr_dirty (port.wr_dirty),
      .hit      (way_hit[w]),
      .line     (way_line[w])
    );
  end

  always_comb begin
    hit_data = '0;
    for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
      if (way_hit[w]) begin
        hit_data = way_line[w].data;
      end
    end
  end

  assign port.hit      = |way_hit;
  assign port.hit_data = hit_data;
  assign port.victim   = way_line[victim_num];

  // fills only happen on misses, so a tag never lives in two ways
  a_single_hit: assert property (@(posedge clock) disable iff (reset) $onehot0(way_hit));

  a_write_on_hit: assert property (@(posedge clock) disable iff (reset)
    port.wr_en && !port.wr_fill |-> port.hit);

endmodule

// File: dcache/dcache_victim_sel.sv
// per-set fill-order tree and victim way encoder

`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_victim_sel (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [dcache_pkg::IDX_W-1:0] set_index,
  input  logic                         advance,
  output dcache_pkg::way_sel_t         victim_way,
  output logic [1:0]                   victim_num
);

  // a picks the half, b ways 0/1, c ways 2/3
  logic [`DCACHE_NUM_IDX-1:0] tree_a;
  logic [`DCACHE_NUM_IDX-1:0] tree_b;
  logic [`DCACHE_NUM_IDX-1:0] tree_c;
  logic                       a;
  logic                       b;
  logic                       c;

  assign a = tree_a[set_index];
  assign b = tree_b[set_index];
  assign c = tree_c[set_index];

  assign victim_way = {a & c, a & ~c, ~a & b, ~a & ~b};

  // only fills move the tree, giving victim order 0, 2, 1, 3
  always_ff @(posedge clock) begin
    if (reset) begin
      tree_a <= '0;
      tree_b <= '0;
      tree_c <= '0;
    end else if (advance) begin
      tree_a[set_index] <= ~a;
      if (!a) begin
        tree_b[set_index] <= ~b;
      end else begin
        tree_c[set_index] <= ~c;
      end
    end
  end

  // or-style encoder of the one-hot victim
  always_comb begin
    victim_num = '0;
    for (int j = 1; j < `DCACHE_NUM_WAY; j++) begin
      if (victim_way[j]) begin
        victim_num = victim_num | 2'(j);
      end
    end
  end

  a_victim_onehot: assert property (@(posedge clock) disable iff (reset) $onehot(victim_way));

endmodule

// File: dcache/dcache_way.sv
// one cache way with per-set line storage, tag compare and line write

`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_way (
  input  logic              clock,
  input  logic              reset,
  input  dcache_pkg::addr_t addr,
  input  logic              wr_en,
  input  wb_pkg::wb_dat_t   wr_data,
  input  logic              wr_dirty,
  output logic              hit,
  output dcache_pkg::line_t line
);

  logic [`DCACHE_NUM_IDX-1:0] valid_q;
  logic [`DCACHE_NUM_IDX-1:0] dirty_q;
  logic [dcache_pkg::TAG_W-1:0] tag_q [`DCACHE_NUM_IDX];
  wb_pkg::wb_dat_t              data_q [`DCACHE_NUM_IDX];
  logic [dcache_pkg::IDX_W-1:0] idx;

  assign idx = addr.set_index;

  // status bits per set
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wr_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= wr_dirty;
    end
  end

  // tag and data storage
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_q[idx]  <= addr.tag;
      data_q[idx] <= wr_data;
    end
  end

  // indexed line doubles as the victim candidate
  assign line = '{valid: valid_q[idx], dirty: dirty_q[idx], tag: tag_q[idx], data: data_q[idx]};

  assign hit = line.valid && (line.tag == addr.tag);

endmodule

// File: common/cache_port_if.sv
// interface between cache controller and tag/data array, with ctrl and array modports

`timescale 1ns/100ps

interface cache_port_if;

  dcache_pkg::addr_t addr;
  logic              wr_en;
  logic              wr_fill;
  wb_pkg::wb_dat_t   wr_data;
  logic              wr_dirty;
  logic              hit;
  wb_pkg::wb_dat_t   hit_data;
  dcache_pkg::line_t victim;

  modport ctrl (
    output addr, wr_en, wr_fill, wr_data, wr_dirty,
    input  hit, hit_data, victim
  );

  modport array (
    input  addr, wr_en, wr_fill, wr_data, wr_dirty,
    output hit, hit_data, victim
  );

endinterface

// File: common/wb_pkg.sv
// Wishbone bus address and data word types

`include "dcache_config.svh"

package wb_pkg;

  // word address, no byte lanes
  typedef logic [`DCACHE_ADDR_W-1:0] wb_adr_t;

  // full data word
  typedef logic [`DCACHE_DATA_W-1:0] wb_dat_t;

endpackage

// File: common/dcache_pkg.sv
// cache storage types for the address split, the line record and the way vector

`include "dcache_config.svh"

package dcache_pkg;

  localparam int IDX_W = $clog2(`DCACHE_NUM_IDX);
  localparam int TAG_W = `DCACHE_ADDR_W - IDX_W;

  // word address split into tag and set
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] set_index;
  } addr_t;

  // one stored line
  typedef struct packed {
    logic                      valid;
    logic                      dirty;
    logic [TAG_W-1:0]          tag;
    logic [`DCACHE_DATA_W-1:0] data;
  } line_t;

  // one bit per way
  typedef logic [`DCACHE_NUM_WAY-1:0] way_sel_t;

endpackage

// File: common/dcache_config.svh
// cache geometry and bus width macros

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// associativity, fixed by the 3-bit replacement tree
`define DCACHE_NUM_WAY 4

// sets per way
`define DCACHE_NUM_IDX 16

// word address width on both buses
`define DCACHE_ADDR_W 16

// one 64-bit word per line
`define DCACHE_DATA_W 64

`endif
